/* list.f */
+incdir+source
source/vz_bus_pkg.sv
source/vz_keyboard_pkg.sv
source/vz_bus_sequencer.sv
source/vz_address_decoder.sv
source/vz_ram.sv
source/vz_video_ram.sv
source/vz_key_matrix.sv
source/vz_io_port.sv
source/vz_laser_top.sv
testbench/tb_vz_laser.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_vz_laser -o tb_vz_laser &&
./obj_dir/tb_vz_laser | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

/* testbench/tb_vz_laser.sv */
`timescale 1ns/1ps

module tb_vz_laser;

	localparam int N_RAM = 40;
	localparam int N_OPEN = 12;
	localparam int N_VRAM = 24;
	localparam int N_IO = 16;
	localparam int N_SHRG = 8;
	localparam int N_KEY_ROUNDS = 12;
	localparam int KEY_READS = 2;
	// Sequencer periods used by all tests, each bus operation takes two
	localparam int TEST_PERIODS = 16 + 2*(2*N_RAM + N_OPEN) + 2*(2*N_VRAM) + N_VRAM + 2
		+ 2*(N_IO + N_SHRG) + N_KEY_ROUNDS*(2 + 2*KEY_READS);
	localparam real WATCHDOG_NS = real'(TEST_PERIODS*14 + 16 + 400) * 20.0;

	localparam logic [3:0] CTL_MEM_RD = 4'b0101;	// {mreq_n, iorq_n, rd_n, wr_n}
	localparam logic [3:0] CTL_MEM_WR = 4'b0110;
	localparam logic [3:0] CTL_IO_WR = 4'b1010;

	// PS/2 code, E0 prefix, slot: 0-63 matrix bit, 64+n extended bit n, -1 ignored
	localparam int N_KEYS = 23;
	localparam logic [7:0] KEY_CODE [N_KEYS] = '{
		8'h1C, 8'h15, 8'h1A, 8'h16, 8'h4D, 8'h4C, 8'h3A, 8'h29, 8'h41, 8'h49, 8'h4E, 8'h12,
		8'h14, 8'h59, 8'h11, 8'h11, 8'h76, 8'h75, 8'h6B, 8'h74, 8'h72, 8'h66, 8'h05
	};
	localparam bit KEY_EXT [N_KEYS] = '{
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 1, 1, 1, 0, 0
	};
	localparam int KEY_SLOT [N_KEYS] = '{
		12, 4, 20, 28, 52, 60, 37, 36, 35, 33, 42, 18,
		10, 64, 65, 66, 67, 68, 69, 70, 71, 72, -1
	};

	logic CLK50MHZ = 1'b0;
	logic RESET_N;
	logic [15:0] cpu_addr_i;
	logic [7:0] cpu_data_i;
	logic cpu_mreq_n_i;
	logic cpu_iorq_n_i;
	logic cpu_rd_n_i;
	logic cpu_wr_n_i;
	logic turbo_i;
	logic shrg_en_i;
	logic cass_in_i;
	logic key_strobe_i;
	logic key_pressed_i;
	logic key_extended_i;
	logic [7:0] key_code_i;
	logic [10:0] vdg_addr_i;
	logic cpu_clk_o;
	logic [7:0] cpu_data_o;
	logic [7:0] vdg_data_o;
	logic vdg_ag_o;
	logic vdg_css_o;
	logic [2:0] vdg_gm_o;
	logic [1:0] speaker_o;
	logic cass_out_o;

	logic [31:0] lcg_state = 32'd20949;
	int checks = 0;
	int errors = 0;
	int test_checks;
	int test_errors;
	logic [7:0] ram_model [16384];
	logic [7:0] vram_model [2048];
	logic [63:0] km = '1;	// Key matrix model, active low
	logic [9:0] kx = '1;
	logic [7:0] shrg_model = 8'h08;
	logic nxt_shrg_en = 1'b0;	// Levels applied with the next bus operation
	logic nxt_cass = 1'b0;

	vz_laser_top i_vz_laser_top
	(
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.cpu_addr_i(cpu_addr_i),
		.cpu_data_i(cpu_data_i),
		.cpu_mreq_n_i(cpu_mreq_n_i),
		.cpu_iorq_n_i(cpu_iorq_n_i),
		.cpu_rd_n_i(cpu_rd_n_i),
		.cpu_wr_n_i(cpu_wr_n_i),
		.turbo_i(turbo_i),
		.shrg_en_i(shrg_en_i),
		.cass_in_i(cass_in_i),
		.key_strobe_i(key_strobe_i),
		.key_pressed_i(key_pressed_i),
		.key_extended_i(key_extended_i),
		.key_code_i(key_code_i),
		.vdg_addr_i(vdg_addr_i),
		.cpu_clk_o(cpu_clk_o),
		.cpu_data_o(cpu_data_o),
		.vdg_data_o(vdg_data_o),
		.vdg_ag_o(vdg_ag_o),
		.vdg_css_o(vdg_css_o),
		.vdg_gm_o(vdg_gm_o),
		.speaker_o(speaker_o),
		.cass_out_o(cass_out_o)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;	// 50 MHz

	function logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// Column bits by the matrix read rule, extended keys folded into their partners
	function automatic logic [5:0] expect_cols(input logic [7:0] mask);
		logic [63:0] eff;
		logic [5:0] cols;
		eff = km;
		eff[37] = km[37] & kx[5] & kx[8];	// M, left, Backspace
		eff[36] = km[36] & kx[7];
		eff[35] = km[35] & kx[6];
		eff[33] = km[33] & kx[4];
		eff[42] = km[42] & kx[3];
		eff[18] = km[18] & kx[0];	// Both shifts
		eff[10] = km[10] & (&kx[8:3]);
		cols = 6'h3F;
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 6; c++)
				if (!mask[r] && !eff[r*8 + c])
					cols[c] = 1'b0;
		return cols;
	endfunction

	task automatic check_hex(input string sig, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %s: got %h, expected %h", sig, got, exp);
		end
	endtask

	task automatic begin_test();
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		$display("%-10s %0d checks, %0d errors", name, checks - test_checks,
			errors - test_errors);
	endtask

	task automatic wait_pulse();
		do
			@(negedge CLK50MHZ);
		while (!cpu_clk_o);
	endtask

	// Park in the cycle after a pulse, where the bus may change
	task automatic align_bus();
		wait_pulse();
		@(negedge CLK50MHZ);
	endtask

	task automatic measure_interval(output int n);
		n = 0;
		do
		begin
			@(negedge CLK50MHZ);
			n++;
		end
		while (!cpu_clk_o);
	endtask

	// Bus held over two pulses, read data taken in the second
	task automatic bus_op(input logic [15:0] addr, input logic [7:0] wdata,
		input logic [3:0] ctl, output logic [7:0] rdata);
		@(posedge CLK50MHZ);
		cpu_addr_i <= addr;
		cpu_data_i <= wdata;
		{cpu_mreq_n_i, cpu_iorq_n_i, cpu_rd_n_i, cpu_wr_n_i} <= ctl;
		shrg_en_i <= nxt_shrg_en;
		cass_in_i <= nxt_cass;
		wait_pulse();
		@(negedge CLK50MHZ);
		wait_pulse();
		rdata = cpu_data_o;
		@(negedge CLK50MHZ);
	endtask

	task automatic key_event(input int k, input logic pressed);
		int slot;
		slot = KEY_SLOT[k];
		@(posedge CLK50MHZ);
		key_code_i <= KEY_CODE[k];
		key_extended_i <= KEY_EXT[k];
		key_pressed_i <= pressed;
		key_strobe_i <= 1'b1;
		@(posedge CLK50MHZ);
		key_strobe_i <= 1'b0;
		if (slot >= 64)
			kx[4'(slot - 64)] = ~pressed;
		else if (slot >= 0)
			km[6'(slot)] = ~pressed;
	endtask

	task automatic test_sequencer();
		int n;
		begin_test();
		repeat (16)
		begin
			@(negedge CLK50MHZ);
			checks++;
			assert (!cpu_clk_o)
			else
			begin
				errors++;
				$display("cpu_clk_o pulsed while RESET_N was still low");
			end
		end
		@(posedge CLK50MHZ);
		RESET_N <= 1'b1;
		wait_pulse();
		repeat (4)
		begin
			measure_interval(n);
			check_hex("cpu_clk_o period", 16'(n), 16'd14);
		end
		@(posedge CLK50MHZ);
		turbo_i <= 1'b1;
		wait_pulse();
		wait_pulse();	// Let the step counter settle in the new mode
		repeat (4)
		begin
			measure_interval(n);
			check_hex("cpu_clk_o period", 16'(n), 16'd4);
		end
		@(posedge CLK50MHZ);
		turbo_i <= 1'b0;
		wait_pulse();
		wait_pulse();
		repeat (2)
		begin
			measure_interval(n);
			check_hex("cpu_clk_o period", 16'(n), 16'd14);
		end
		align_bus();
		end_test("sequencer");
	endtask

	task automatic test_ram();
		logic [15:0] addr;
		logic [15:0] r;
		logic [7:0] rd;
		logic [15:0] addrs [$];
		begin_test();
		repeat (N_RAM)
		begin
			r = next_random();
			addr = 16'h7800 + next_random() % 16'h4000;
			bus_op(addr, r[7:0], CTL_MEM_WR, rd);
			ram_model[addr[13:0]] = r[7:0];
			addrs.push_back(addr);
		end
		foreach (addrs[i])
		begin
			addr = addrs[i];
			bus_op(addr, 8'h00, CTL_MEM_RD, rd);
			check_hex("cpu_data_o", {8'h00, rd}, {8'h00, ram_model[addr[13:0]]});
		end
		repeat (N_OPEN)
		begin
			r = next_random();
			if (r[0])
				addr = r % 16'h6800;
			else
				addr = 16'hB800 + r % 16'h4800;	// Above the RAM windows
			bus_op(addr, 8'h00, CTL_MEM_RD, rd);
			check_hex("cpu_data_o", {8'h00, rd}, 16'h00FF);
		end
		end_test("ram");
	endtask

	task automatic test_vram();
		logic [15:0] addr;
		logic [15:0] r;
		logic [7:0] rd;
		logic [15:0] addrs [$];
		begin_test();
		repeat (N_VRAM)
		begin
			r = next_random();
			addr = 16'h7000 + next_random() % 16'h0800;
			bus_op(addr, r[7:0], CTL_MEM_WR, rd);
			vram_model[addr[10:0]] = r[7:0];
			addrs.push_back(addr);
		end
		foreach (addrs[i])
		begin
			addr = addrs[i];
			bus_op(addr, 8'h00, CTL_MEM_RD, rd);
			check_hex("cpu_data_o", {8'h00, rd}, {8'h00, vram_model[addr[10:0]]});
		end
		// Video port, one cycle from address to data
		foreach (addrs[i])
		begin
			addr = addrs[i];
			@(posedge CLK50MHZ);
			vdg_addr_i <= addr[10:0];
			@(posedge CLK50MHZ);
			@(negedge CLK50MHZ);
			check_hex("vdg_data_o", {8'h00, vdg_data_o}, {8'h00, vram_model[addr[10:0]]});
		end
		align_bus();
		end_test("vram");
	endtask

	task automatic test_io();
		logic [15:0] addr;
		logic [15:0] r;
		logic [7:0] d;
		logic [7:0] port;
		logic [7:0] rd;
		begin_test();
		check_hex("vdg_gm_o", 16'(vdg_gm_o), 16'h0002);
		repeat (N_IO)
		begin
			r = next_random();
			d = r[7:0];
			addr = 16'h6800 + next_random() % 16'h0800;
			bus_op(addr, d, CTL_MEM_WR, rd);
			check_hex("vdg_ag_o", 16'(vdg_ag_o), 16'(d[3]));
			check_hex("vdg_css_o", 16'(vdg_css_o), 16'(d[4]));
			check_hex("speaker_o", 16'(speaker_o), 16'({d[0], d[5]}));
			check_hex("cass_out_o", 16'(cass_out_o), 16'(d[2]));
		end
		for (int i = 0; i < N_SHRG; i++)
		begin
			r = next_random();
			d = r[7:0];
			nxt_shrg_en = (i == 0) ? 1'b1 : (i == 1) ? 1'b0 : r[8];
			port = (i < 2 || r[9]) ? 8'd32 : (r[15:8] | 8'h40);	// Bit 6 set never hits 32
			bus_op({r[15:8], port}, d, CTL_IO_WR, rd);
			if (nxt_shrg_en && port == 8'd32)
				shrg_model = d;
			check_hex("vdg_gm_o", 16'(vdg_gm_o), 16'(shrg_model[4:2]));
		end
		end_test("io");
	endtask

	task automatic test_keys();
		logic [15:0] r;
		logic [15:0] addr;
		logic [7:0] mask;
		logic [7:0] rd;
		begin_test();
		repeat (N_KEY_ROUNDS)
		begin
			repeat (3)
			begin
				r = next_random();
				key_event(int'(r % 16'(N_KEYS)), r[12]);
			end
			align_bus();
			repeat (KEY_READS)
			begin
				r = next_random();
				mask = (r[15:14] == 2'b00) ? 8'hFF : r[7:0];
				nxt_cass = r[8];
				addr = 16'h6800 | {5'b00000, r[11:9], mask};
				bus_op(addr, 8'h00, CTL_MEM_RD, rd);
				check_hex("cpu_data_o", {8'h00, rd}, {8'h00, 1'b1, ~nxt_cass, expect_cols(mask)});
			end
		end
		end_test("keyboard");
	endtask

	initial
	begin
		RESET_N = 1'b0;
		cpu_addr_i = 16'h0000;
		cpu_data_i = 8'h00;
		cpu_mreq_n_i = 1'b1;
		cpu_iorq_n_i = 1'b1;
		cpu_rd_n_i = 1'b1;
		cpu_wr_n_i = 1'b1;
		turbo_i = 1'b0;
		shrg_en_i = 1'b0;
		cass_in_i = 1'b0;
		key_strobe_i = 1'b0;
		key_pressed_i = 1'b0;
		key_extended_i = 1'b0;
		key_code_i = 8'h00;
		vdg_addr_i = 11'h000;
		test_sequencer();
		test_ram();
		test_vram();
		test_io();
		test_keys();
		$display("5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout, the tests did not finish in time");
		$display("test failed");
		$finish;
	end

endmodule

/* source/vz_laser_top.sv */
`timescale 1ns/1ps
`include "vz_macros.svh"

module vz_laser_top
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  vz_bus_pkg::addr_t cpu_addr_i,
	input  vz_bus_pkg::data_t cpu_data_i,
	input  logic cpu_mreq_n_i,
	input  logic cpu_iorq_n_i,
	input  logic cpu_rd_n_i,
	input  logic cpu_wr_n_i,
	input  logic turbo_i,
	input  logic shrg_en_i,
	input  logic cass_in_i,
	input  logic key_strobe_i,
	input  logic key_pressed_i,
	input  logic key_extended_i,
	input  logic [7:0] key_code_i,
	input  logic [`VZ_VRAM_ADDR_W-1:0] vdg_addr_i,
	output logic cpu_clk_o,
	output vz_bus_pkg::data_t cpu_data_o,
	output vz_bus_pkg::data_t vdg_data_o,
	output logic vdg_ag_o,
	output logic vdg_css_o,
	output logic [2:0] vdg_gm_o,
	output logic [1:0] speaker_o,
	output logic cass_out_o
);

	logic bus_latch;
	logic mem_wr;
	logic ram_we;
	logic vram_we;
	vz_bus_pkg::region_e region;
	logic [`VZ_RAM_ADDR_W-1:0] ram_addr;
	vz_bus_pkg::data_t ram_data;
	vz_bus_pkg::data_t vram_data;
	vz_bus_pkg::data_t key_data;
	vz_bus_pkg::io_latch_t io_latch;
	vz_bus_pkg::data_t shrg;
	vz_keyboard_pkg::key_col_t column;

	vz_bus_sequencer i_vz_bus_sequencer
	(
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.turbo_i(turbo_i),
		.cpu_clk_o(cpu_clk_o),
		.bus_latch_o(bus_latch)
	);

	vz_address_decoder i_vz_address_decoder
	(
		.cpu_addr_i(cpu_addr_i),
		.cpu_mreq_n_i(cpu_mreq_n_i),
		.region_o(region),
		.ram_addr_o(ram_addr)
	);

	// Plain memory write, strobed by the CPU clock pulse
	assign mem_wr = cpu_clk_o && !cpu_wr_n_i && cpu_rd_n_i && cpu_iorq_n_i;
	assign ram_we = mem_wr && (region == vz_bus_pkg::REGION_RAM);
	assign vram_we = mem_wr && (region == vz_bus_pkg::REGION_VRAM);

	vz_ram #(.ADDR_W(`VZ_RAM_ADDR_W)) i_vz_ram
	(
		.CLK50MHZ(CLK50MHZ),
		.addr_i(ram_addr),
		.data_i(cpu_data_i),
		.we_i(ram_we),
		.data_o(ram_data)
	);

	vz_video_ram i_vz_video_ram
	(
		.CLK50MHZ(CLK50MHZ),
		.cpu_addr_i(cpu_addr_i[`VZ_VRAM_ADDR_W-1:0]),
		.cpu_data_i(cpu_data_i),
		.cpu_we_i(vram_we),
		.vdg_addr_i(vdg_addr_i),
		.cpu_data_o(vram_data),
		.vdg_data_o(vdg_data_o)
	);

	vz_key_matrix i_vz_key_matrix
	(
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.key_strobe_i(key_strobe_i),
		.key_pressed_i(key_pressed_i),
		.key_extended_i(key_extended_i),
		.key_code_i(key_code_i),
		.row_sel_i(cpu_addr_i[7:0]),
		.column_o(column)
	);

	vz_io_port i_vz_io_port
	(
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.bus_latch_i(bus_latch),
		.region_i(region),
		.cpu_addr_i(cpu_addr_i),
		.cpu_data_i(cpu_data_i),
		.cpu_iorq_n_i(cpu_iorq_n_i),
		.cpu_wr_n_i(cpu_wr_n_i),
		.shrg_en_i(shrg_en_i),
		.cass_in_i(cass_in_i),
		.column_i(column),
		.key_data_o(key_data),
		.io_latch_o(io_latch),
		.shrg_o(shrg)
	);

	// Read mux, open bus reads as FF
	always_comb
	begin
		case (region)
			vz_bus_pkg::REGION_IO: cpu_data_o = key_data;
			vz_bus_pkg::REGION_VRAM: cpu_data_o = vram_data;
			vz_bus_pkg::REGION_RAM: cpu_data_o = ram_data;
			default: cpu_data_o = 8'hFF;
		endcase
	end

	assign vdg_gm_o = shrg[4:2];
	assign vdg_ag_o = io_latch.ag;
	assign vdg_css_o = io_latch.css;
	assign speaker_o = {io_latch.spk_a, io_latch.spk_b};	// Two speaker pins
	assign cass_out_o = io_latch.cass_out;

endmodule

/* source/vz_io_port.sv */
`timescale 1ns/1ps
`include "vz_macros.svh"

module vz_io_port
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic bus_latch_i,
	input  vz_bus_pkg::region_e region_i,
	input  vz_bus_pkg::addr_t cpu_addr_i,
	input  vz_bus_pkg::data_t cpu_data_i,
	input  logic cpu_iorq_n_i,
	input  logic cpu_wr_n_i,
	input  logic shrg_en_i,
	input  logic cass_in_i,
	input  vz_keyboard_pkg::key_col_t column_i,
	output vz_bus_pkg::data_t key_data_o,
	output vz_bus_pkg::io_latch_t io_latch_o,
	output vz_bus_pkg::data_t shrg_o
);

	logic io_wr;
	logic shrg_wr;

	// Memory write into 6800-6FFF
	assign io_wr = bus_latch_i && (region_i == vz_bus_pkg::REGION_IO)
		&& !cpu_wr_n_i && cpu_iorq_n_i;
	// OUT (32),A with the SHRG switch on
	assign shrg_wr = bus_latch_i && shrg_en_i && !cpu_iorq_n_i && !cpu_wr_n_i
		&& (cpu_addr_i[7:0] == 8'(`VZ_SHRG_PORT));

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			io_latch_o <= '0;
			shrg_o <= vz_bus_pkg::SHRG_RESET;
		end
		else
		begin
			if (io_wr)
				io_latch_o <= cpu_data_i;
			if (shrg_wr)
				shrg_o <= cpu_data_i;
		end
	end

	// Keyboard byte snapshot, cassette input inverted in bit 6
	always_ff @(posedge CLK50MHZ)
	begin
		if (bus_latch_i)
			key_data_o <= {1'b1, ~cass_in_i, column_i};
	end

endmodule

/* source/vz_key_matrix.sv */
`timescale 1ns/1ps

module vz_key_matrix
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic key_strobe_i,
	input  logic key_pressed_i,
	input  logic key_extended_i,
	input  logic [7:0] key_code_i,
	input  logic [7:0] row_sel_i,	// Low address byte, a 0 selects the row
	output vz_keyboard_pkg::key_col_t column_o
);

	vz_keyboard_pkg::key_matrix_t key_q;
	vz_keyboard_pkg::key_ex_t key_ex_q;
	vz_keyboard_pkg::key_matrix_t key_eff;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_q <= '1;
			key_ex_q <= '1;
		end
		else if (key_strobe_i)
		begin
			for (int i = 0; i < vz_keyboard_pkg::MATRIX_KEYS; i++)
				if (key_code_i == vz_keyboard_pkg::MATRIX_CODE[i])
					key_q[vz_keyboard_pkg::MATRIX_INDEX[i]] <= ~key_pressed_i;
			for (int i = 0; i < vz_keyboard_pkg::EX_KEYS; i++)
				if (key_code_i == vz_keyboard_pkg::EX_CODE[i])
					key_ex_q[vz_keyboard_pkg::EX_INDEX[i]] <= ~key_pressed_i;
			if (key_code_i == vz_keyboard_pkg::SC_ALT)
			begin
				if (key_extended_i)
					key_ex_q[vz_keyboard_pkg::EX_R_ALT] <= ~key_pressed_i;
				else
					key_ex_q[vz_keyboard_pkg::EX_L_ALT] <= ~key_pressed_i;
			end
		end
	end

	// PC-only keys show up as Ctrl combinations on the VZ matrix
	always_comb
	begin
		key_eff = key_q;
		key_eff[37] = key_q[37] & key_ex_q[vz_keyboard_pkg::EX_LEFT]
			& key_ex_q[vz_keyboard_pkg::EX_BKSP];	// M
		key_eff[36] = key_q[36] & key_ex_q[vz_keyboard_pkg::EX_DOWN];	// Space
		key_eff[35] = key_q[35] & key_ex_q[vz_keyboard_pkg::EX_RIGHT];	// Comma
		key_eff[33] = key_q[33] & key_ex_q[vz_keyboard_pkg::EX_UP];	// Period
		key_eff[42] = key_q[42] & key_ex_q[vz_keyboard_pkg::EX_ESC];	// Minus
		key_eff[18] = key_q[18] & key_ex_q[vz_keyboard_pkg::EX_R_SHIFT];	// Both shifts
		key_eff[10] = key_q[10] & (&key_ex_q[8:3]);	// Ctrl
	end

	// A column reads low if any selected row has that key down
	always_comb
	begin
		column_o = '1;
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 6; c++)
				if (!row_sel_i[r] && !key_eff[r*8 + c])
					column_o[c] = 1'b0;
	end

	a_no_row_idle: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		(row_sel_i == 8'hFF) |-> (column_o == '1));

endmodule

/* source/vz_video_ram.sv */
`timescale 1ns/1ps
`include "vz_macros.svh"

module vz_video_ram
(
	input  logic CLK50MHZ,
	input  logic [`VZ_VRAM_ADDR_W-1:0] cpu_addr_i,
	input  vz_bus_pkg::data_t cpu_data_i,
	input  logic cpu_we_i,
	input  logic [`VZ_VRAM_ADDR_W-1:0] vdg_addr_i,
	output vz_bus_pkg::data_t cpu_data_o,
	output vz_bus_pkg::data_t vdg_data_o
);

	vz_bus_pkg::data_t mem [2**`VZ_VRAM_ADDR_W];

	// CPU side
	always_ff @(posedge CLK50MHZ)
	begin
		if (cpu_we_i)
			mem[cpu_addr_i] <= cpu_data_i;
		cpu_data_o <= mem[cpu_addr_i];
	end

	// Video fetch side, read only
	always_ff @(posedge CLK50MHZ)
	begin
		vdg_data_o <= mem[vdg_addr_i];
	end

endmodule

/* source/vz_ram.sv */
`timescale 1ns/1ps
`include "vz_macros.svh"

module vz_ram
#(
	parameter int ADDR_W = `VZ_RAM_ADDR_W
)
(
	input  logic CLK50MHZ,
	input  logic [ADDR_W-1:0] addr_i,
	input  vz_bus_pkg::data_t data_i,
	input  logic we_i,
	output vz_bus_pkg::data_t data_o
);

	vz_bus_pkg::data_t mem [2**ADDR_W];

	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_i] <= data_i;
		data_o <= mem[addr_i];	// Old data on a write cycle
	end

endmodule

/* source/vz_address_decoder.sv */
`timescale 1ns/1ps
`include "vz_macros.svh"

module vz_address_decoder
(
	input  vz_bus_pkg::addr_t cpu_addr_i,
	input  logic cpu_mreq_n_i,
	output vz_bus_pkg::region_e region_o,
	output logic [`VZ_RAM_ADDR_W-1:0] ram_addr_o
);

	// The three RAM windows land on distinct low 14 bits
	assign ram_addr_o = cpu_addr_i[`VZ_RAM_ADDR_W-1:0];

	always_comb
	begin
		region_o = vz_bus_pkg::REGION_NONE;
		if (!cpu_mreq_n_i)
		begin
			case (cpu_addr_i[15:11])
				5'b01101: region_o = vz_bus_pkg::REGION_IO;	// 6800-6FFF
				5'b01110: region_o = vz_bus_pkg::REGION_VRAM;	// 7000-77FF
				5'b01111: region_o = vz_bus_pkg::REGION_RAM;	// 7800-7FFF
				5'b10000, 5'b10001, 5'b10010, 5'b10011,
				5'b10100, 5'b10101: region_o = vz_bus_pkg::REGION_RAM;	// 8000-AFFF
				5'b10110: region_o = vz_bus_pkg::REGION_RAM;	// B000-B7FF
				default: region_o = vz_bus_pkg::REGION_NONE;
			endcase
		end
	end

endmodule

/* source/vz_bus_sequencer.sv */
`timescale 1ns/1ps
`include "vz_macros.svh"

module vz_bus_sequencer
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic bus_latch_o
);

	localparam int STEP_W = $clog2(`VZ_SEQ_LAST_NORMAL + 1);
	localparam logic [STEP_W-1:0] LAST_NORMAL = STEP_W'(`VZ_SEQ_LAST_NORMAL);
	localparam logic [STEP_W-1:0] LAST_TURBO = STEP_W'(`VZ_SEQ_LAST_TURBO);

	logic [STEP_W-1:0] step_q;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			step_q <= '0;
			cpu_clk_o <= 1'b0;
			bus_latch_o <= 1'b0;
		end
		else
		begin
			cpu_clk_o <= (step_q == '0);	// Also the memory write strobe
			bus_latch_o <= cpu_clk_o;
			// Turbo only decides at the short wrap point
			if (step_q == LAST_TURBO && turbo_i)
				step_q <= '0;
			else if (step_q == LAST_NORMAL)
				step_q <= '0;
			else
				step_q <= step_q + 1'b1;
		end
	end

	a_strobes_apart: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		!(cpu_clk_o && bus_latch_o));

	a_latch_after_clk: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		cpu_clk_o |=> bus_latch_o);

endmodule

/* source/vz_keyboard_pkg.sv */
package vz_keyboard_pkg;

	typedef logic [63:0] key_matrix_t;	// Row r in bits r*8+7 to r*8, active low
	typedef logic [9:0] key_ex_t;	// Extended keys, active low
	typedef logic [5:0] key_col_t;

	// Extended key bits
	localparam logic [3:0] EX_R_SHIFT = 4'd0;
	localparam logic [3:0] EX_L_ALT = 4'd1;
	localparam logic [3:0] EX_R_ALT = 4'd2;
	localparam logic [3:0] EX_ESC = 4'd3;
	localparam logic [3:0] EX_UP = 4'd4;
	localparam logic [3:0] EX_LEFT = 4'd5;
	localparam logic [3:0] EX_RIGHT = 4'd6;
	localparam logic [3:0] EX_DOWN = 4'd7;
	localparam logic [3:0] EX_BKSP = 4'd8;

	// Alt shares one code, the E0 prefix picks the right one
	localparam logic [7:0] SC_ALT = 8'h11;

	// Scan codes of the matrix keys and their bit in key_matrix_t
	localparam int MATRIX_KEYS = 45;
	localparam logic [7:0] MATRIX_CODE [MATRIX_KEYS] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45,	// 1 to 0
		8'h4E, 8'h49, 8'h4B, 8'h44, 8'h5A, 8'h52, 8'h1D, 8'h24, 8'h2D, 8'h2C,	// - . L O CR ' W E R T
		8'h35, 8'h3C, 8'h43, 8'h1B, 8'h23, 8'h2B, 8'h34, 8'h33, 8'h3B, 8'h42,	// Y U I S D F G H J K
		8'h22, 8'h21, 8'h2A, 8'h32, 8'h31, 8'h3A, 8'h41, 8'h15, 8'h1C, 8'h1A,	// X C V B N M , Q A Z
		8'h29, 8'h4C, 8'h4D, 8'h14, 8'h12	// Space ; P Ctrl L-Shift
	};
	localparam logic [5:0] MATRIX_INDEX [MATRIX_KEYS] = '{
		6'd28, 6'd25, 6'd27, 6'd29, 6'd24, 6'd40, 6'd45, 6'd43, 6'd41, 6'd44,
		6'd42, 6'd33, 6'd57, 6'd49, 6'd50, 6'd58, 6'd1, 6'd3, 6'd5, 6'd0,
		6'd48, 6'd53, 6'd51, 6'd9, 6'd11, 6'd13, 6'd8, 6'd56, 6'd61, 6'd59,
		6'd17, 6'd19, 6'd21, 6'd16, 6'd32, 6'd37, 6'd35, 6'd4, 6'd12, 6'd20,
		6'd36, 6'd60, 6'd52, 6'd10, 6'd18
	};

	// R-Shift, Esc, arrows up left right down, Backspace
	localparam int EX_KEYS = 7;
	localparam logic [7:0] EX_CODE [EX_KEYS] = '{
		8'h59, 8'h76, 8'h75, 8'h6B, 8'h74, 8'h72, 8'h66
	};
	localparam logic [3:0] EX_INDEX [EX_KEYS] = '{
		EX_R_SHIFT, EX_ESC, EX_UP, EX_LEFT, EX_RIGHT, EX_DOWN, EX_BKSP
	};

endpackage

/* source/vz_bus_pkg.sv */
`include "vz_macros.svh"

package vz_bus_pkg;

	typedef logic [`VZ_ADDR_W-1:0] addr_t;
	typedef logic [`VZ_DATA_W-1:0] data_t;

	// What a CPU memory access hits
	typedef enum logic [1:0]
	{
		REGION_NONE,
		REGION_IO,	// 6800-6FFF
		REGION_VRAM,	// 7000-77FF
		REGION_RAM	// 7800-B7FF
	} region_e;

	// Output latch at 6800-6FFF
	typedef struct packed
	{
		logic spare7;
		logic spare6;
		logic spk_b;
		logic css;	// Colour set select
		logic ag;	// Alpha or graphics
		logic cass_out;
		logic spare1;
		logic spk_a;
	} io_latch_t;

	// Graphics mode 010 out of reset
	localparam data_t SHRG_RESET = 8'h08;

endpackage

/* source/vz_macros.svh */
`ifndef VZ_MACROS_SVH
`define VZ_MACROS_SVH

// CPU bus widths
`define VZ_ADDR_W 16
`define VZ_DATA_W 8

// Main RAM is 16 KB, video RAM 2 KB
`define VZ_RAM_ADDR_W 14
`define VZ_VRAM_ADDR_W 11

// Last sequencer step, normal speed and turbo
`define VZ_SEQ_LAST_NORMAL 13
`define VZ_SEQ_LAST_TURBO 3

// Low I/O address byte of the SHRG mode port
`define VZ_SHRG_PORT 32

`endif
